/* design/act_settings.svh */
`ifndef ACT_SETTINGS_SVH
`define ACT_SETTINGS_SVH

// Element format, signed fixed point
`define ACT_DATA_W 8 // Total bits per element
`define ACT_FRAC_W 4 // Fraction bits, so 1.0 is raw 16

// Vector width of one stream beat
`define ACT_LANES 4

// The +-3 region bounds of HardSwish, as raw fixed-point values
`define ACT_THREE_FX (3 << `ACT_FRAC_W)

`endif

/* design/act_pkg.sv */
`include "act_settings.svh"

package act_pkg;

  // One signed fixed-point element
  typedef logic signed [`ACT_DATA_W-1:0] elem_t;

  // One element plus a guard bit, wide enough for x + 3
  typedef logic signed [`ACT_DATA_W:0] sum_t;

  // Full-width signed product of two elements
  typedef logic signed [2*`ACT_DATA_W-1:0] prod_t;

  // Stream payload, lane 0 in the low bits
  typedef struct packed {
    elem_t [`ACT_LANES-1:0] lane;
  } vec_t;

  // Which branch of HardSwish a lane falls into
  typedef enum logic [1:0] {
    REG_ZERO  = 2'd0, // x < -3
    REG_PASS  = 2'd1, // x >= 3
    REG_CURVE = 2'd2  // -3 <= x < 3
  } region_t;

  // Per-lane state handed from prep to multiply, 18 bits by default
  typedef struct packed {
    elem_t   x;
    region_t region;
    elem_t   s; // Approximate (x+3)/6 scale
  } prep_lane_t;

  typedef struct packed {
    prep_lane_t [`ACT_LANES-1:0] lane;
  } prep_t;

endpackage

/* design/pipe_stage.sv */
`timescale 1ns/1ps

// One-entry valid/ready register slice. It accepts a new beat whenever it
// is empty or its current beat leaves on the same edge, so a chain of these
// streams at one beat per cycle and fills from the back under stall.
module pipe_stage import act_pkg::*; #(
  parameter type payload_t = vec_t
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream side
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     ready_out,

  // Downstream side
  output logic     valid_out,
  output payload_t data_out,
  input  logic     ready_in
);

  logic load; // Slot is free this cycle

  // Free when empty or draining
  assign load      = !valid_out || ready_in;
  assign ready_out = load;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else if (load) begin
      valid_out <= valid_in; // Bubble in if upstream has nothing
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (load) begin
      data_out <= data_in;
    end
  end

endmodule

/* design/hardswish_prep.sv */
`timescale 1ns/1ps
`include "act_settings.svh"

// First compute step of HardSwish. Each lane is classified against the
// fixed-point +-3 bounds, and the curve scale (x+3)*3/16 is formed from
// two arithmetic shifts, an approximation of (x+3)/6.
module hardswish_prep import act_pkg::*; (
  input  vec_t  x_vec,
  output prep_t prep
);

  // Threshold in element and guard widths
  localparam int   THREE_FX  = `ACT_THREE_FX;
  localparam sum_t THREE_SUM = sum_t'(THREE_FX);

  for (genvar i = 0; i < `ACT_LANES; i++) begin : g_lane

    elem_t   x;
    sum_t    x_ext;  // Sign-extended element
    sum_t    t;      // x + 3 in fixed point
    sum_t    s_wide; // t/8 + t/16 before truncation
    region_t region;

    assign x     = x_vec.lane[i];
    assign x_ext = x;

    // Guard bit keeps x + 48 from wrapping
    assign t = x_ext + THREE_SUM;

    // 1/8 + 1/16 = 3/16, close to 1/6
    assign s_wide = (t >>> 3) + (t >>> 4);

    // Region decision, signed compare at raw +-48
    always_comb begin
      if (x < -THREE_FX) begin
        region = REG_ZERO;
      end else if (x >= THREE_FX) begin
        region = REG_PASS;
      end else begin
        region = REG_CURVE;
      end
    end

    // In the curve region t is 0..95, so s is at most 16 and fits
    assign prep.lane[i].x      = x;
    assign prep.lane[i].region = region;
    assign prep.lane[i].s      = s_wide[`ACT_DATA_W-1:0];

  end

endmodule

/* design/hardswish_mult.sv */
`timescale 1ns/1ps
`include "act_settings.svh"

// Second compute step of HardSwish. The curve branch is x * s with the
// product shifted back by the fraction width; the other two branches only
// select zero or x. The result is cut to the element width.
module hardswish_mult import act_pkg::*; (
  input  prep_t prep,
  output vec_t  y_vec
);

  for (genvar i = 0; i < `ACT_LANES; i++) begin : g_lane

    elem_t   x;
    elem_t   s;
    region_t region;
    prod_t   prod;    // Full signed x * s
    prod_t   prod_sh; // Back in element fixed point
    elem_t   y;

    assign x      = prep.lane[i].x;
    assign s      = prep.lane[i].s;
    assign region = prep.lane[i].region;

    // Both operands signed, so the product is too
    assign prod = x * s;

    // Floor division by 2^FRAC
    assign prod_sh = prod >>> `ACT_FRAC_W;

    // Curve output lies in about -0.4..2.9, no saturation
    always_comb begin
      case (region)
        REG_PASS: begin
          y = x;
        end
        REG_CURVE: begin
          y = prod_sh[`ACT_DATA_W-1:0];
        end
        default: begin
          y = '0; // REG_ZERO
        end
      endcase
    end

    assign y_vec.lane[i] = y;

  end

endmodule

/* design/hardswish_pipeline.sv */
`timescale 1ns/1ps

// Streaming HardSwish unit, three register stages deep.
//   stage 0  registers the input vector
//   prep     classifies lanes and forms the scale, combinational
//   stage 1  registers the per-lane prep state
//   mult     multiplies and selects, combinational
//   stage 2  drives the output stream
// Latency is three cycles with one beat per cycle throughput.
module hardswish_pipeline import act_pkg::*; (
  input  logic clk,
  input  logic rst_n,

  // Input stream
  input  vec_t in_data,
  input  logic in_valid,
  output logic in_ready,

  // Output stream
  output vec_t out_data,
  output logic out_valid,
  input  logic out_ready
);

  // Stage 0 to prep
  vec_t  in_stage_data;
  logic  in_stage_valid;
  logic  in_stage_ready; // Back from stage 1

  // Prep to stage 1
  prep_t prep_comb;

  // Stage 1 to mult
  prep_t prep_stage_data;
  logic  prep_stage_valid;
  logic  prep_stage_ready; // Back from stage 2

  // Mult to stage 2
  vec_t  mult_comb;

  pipe_stage #(
    .payload_t (vec_t)
  ) u_in_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (in_valid),
    .data_in   (in_data),
    .ready_out (in_ready),
    .valid_out (in_stage_valid),
    .data_out  (in_stage_data),
    .ready_in  (in_stage_ready)
  );

  hardswish_prep u_prep (
    .x_vec (in_stage_data),
    .prep  (prep_comb)
  );

  pipe_stage #(
    .payload_t (prep_t)
  ) u_prep_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (in_stage_valid),
    .data_in   (prep_comb),
    .ready_out (in_stage_ready),
    .valid_out (prep_stage_valid),
    .data_out  (prep_stage_data),
    .ready_in  (prep_stage_ready)
  );

  hardswish_mult u_mult (
    .prep  (prep_stage_data),
    .y_vec (mult_comb)
  );

  // Last slice faces the consumer directly
  pipe_stage #(
    .payload_t (vec_t)
  ) u_out_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (prep_stage_valid),
    .data_in   (mult_comb),
    .ready_out (prep_stage_ready),
    .valid_out (out_valid),
    .data_out  (out_data),
    .ready_in  (out_ready)
  );

endmodule

/* verif/hardswish_checker.sv */
`timescale 1ns/1ps
`include "act_settings.svh"

// Scoreboard for the HardSwish stream. It queues every accepted input beat,
// predicts the output with its own model, and compares in arrival order.
module hardswish_checker import act_pkg::*; (
  input logic clk,
  input logic rst_n,
  input vec_t in_data,
  input logic in_valid,
  input logic in_ready,
  input vec_t out_data,
  input logic out_valid,
  input logic out_ready
);

  string test_name = "none";     // Set by the testbench top
  int    compared_count = 0;
  int    error_count = 0;

  vec_t  expect_q[$];
  logic  stall_seen = 1'b0;      // Output offered but not taken
  vec_t  stall_data = '0;

  // HardSwish model, lane by lane in plain integers
  function automatic vec_t hardswish_ref(input vec_t x_vec);
    vec_t y_vec;
    int   three;
    int   x;
    int   t;
    int   s;
    int   y;
    three = 3 * (1 << `ACT_FRAC_W); // 3.0 in raw units
    for (int i = 0; i < `ACT_LANES; i++) begin
      x = x_vec.lane[i];
      if (x < -three) begin
        y = 0;
      end else if (x >= three) begin
        y = x;
      end else begin
        t = x + three;
        s = (t >>> 3) + (t >>> 4);
        y = (x * s) >>> `ACT_FRAC_W; // Floor shift
      end
      y_vec.lane[i] = elem_t'(y);
    end
    return y_vec;
  endfunction

  always @(posedge clk) begin
    vec_t expected;
    int   errs;
    errs = 0;
    if (rst_n) begin
      if (in_valid && in_ready) begin
        expect_q.push_back(in_data);
      end
      if (stall_seen && (!out_valid || out_data !== stall_data)) begin
        $display("Error %s: output beat changed or vanished before it was accepted",
                 test_name);
        errs++;
      end
      if (out_valid && out_ready) begin
        if (expect_q.size() == 0) begin
          $display("Error %s: output beat arrived with no input beat pending", test_name);
          errs++;
        end else begin
          expected = hardswish_ref(expect_q.pop_front());
          if (out_data !== expected) begin
            $display("Error %s: expected %h actual %h", test_name, expected, out_data);
            errs++;
          end
          compared_count <= compared_count + 1;
        end
      end
      stall_seen <= out_valid && !out_ready;
      stall_data <= out_data;
    end
    error_count <= error_count + errs;
  end

endmodule

/* verif/tb_hardswish.sv */
`timescale 1ns/1ps
`include "act_settings.svh"

module tb_hardswish import act_pkg::*; ();

  localparam int CYCLES_PER_BEAT = 30; // Timeout budget

  logic clk = 1'b0;
  logic rst_n;
  vec_t in_data;
  logic in_valid;
  logic in_ready;
  vec_t out_data;
  logic out_valid;
  logic out_ready;

  vec_t stim_q[$];
  int   pass_count = 0;
  int   fail_count = 0;

  always #10 clk = ~clk;

  hardswish_pipeline hardswish_pipeline_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  hardswish_checker u_checker (.*);

  function automatic vec_t random_vec();
    vec_t v;
    for (int i = 0; i < `ACT_LANES; i++) begin
      v.lane[i] = elem_t'($urandom());
    end
    return v;
  endfunction

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed", name);
    end
  endtask

  // Sends stim_q and waits until every beat has been compared
  task automatic stream_beats(input string name, input int gap_pct, input int stall_pct,
                              input bit full_rate);
    int n;
    int idx;
    int cycles;
    int target;
    int errs_before;
    int run;
    int best_run;
    bit ok;
    n = stim_q.size();
    idx = 0;
    cycles = 0;
    run = 0;
    best_run = 0;
    ok = 1'b1;
    target = u_checker.compared_count + n;
    errs_before = u_checker.error_count;
    u_checker.test_name = name;
    while ((idx < n || u_checker.compared_count < target) &&
           cycles < n * CYCLES_PER_BEAT + 50) begin
      @(posedge clk);
      cycles++;
      if (in_valid && in_ready) begin
        idx++;
      end
      if (full_rate && in_valid && !in_ready) begin
        $display("Error %s: in_ready dropped during a full-rate stream", name);
        ok = 1'b0;
      end
      run = (out_valid && out_ready) ? run + 1 : 0;
      best_run = (run > best_run) ? run : best_run;
      if (!in_valid || in_ready) begin // Hold a beat until it is taken
        if (idx < n && $urandom_range(99) >= gap_pct) begin
          in_valid <= 1'b1;
          in_data  <= stim_q[idx];
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= ($urandom_range(99) >= stall_pct);
    end
    if (u_checker.compared_count < target) begin
      $display("Timeout in test %s: outputs stopped arriving", name);
      ok = 1'b0;
    end
    if (full_rate && best_run < n) begin
      $display("Test %s: outputs did not arrive on %0d consecutive cycles", name, n);
      ok = 1'b0;
    end
    out_ready <= 1'b1;
    report_test(name, ok && u_checker.error_count == errs_before);
  endtask

  initial begin
    int   directed[9];
    vec_t v;
    void'($urandom(63510));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    u_checker.test_name = "reset_state";
    @(posedge clk);
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("Test reset_state: out_valid or in_ready wrong after reset");
      report_test("reset_state", 1'b0);
    end else begin
      report_test("reset_state", 1'b1);
    end

    // Both threshold edges plus the extremes, rotated through every lane
    directed = '{-128, -49, -48, -1, 0, 1, 47, 48, 127};
    stim_q.delete();
    for (int k = 0; k < 9; k++) begin
      for (int i = 0; i < `ACT_LANES; i++) begin
        v.lane[i] = elem_t'(directed[(k + i) % 9]);
      end
      stim_q.push_back(v);
    end
    stream_beats("directed_regions", 0, 0, 1'b0);

    stim_q.delete();
    repeat (200) stim_q.push_back(random_vec());
    stream_beats("random_stream", 0, 0, 1'b0);

    stim_q.delete();
    repeat (200) stim_q.push_back(random_vec());
    stream_beats("backpressure", 30, 40, 1'b0);

    stim_q.delete();
    repeat (50) stim_q.push_back(random_vec());
    stream_beats("full_throughput", 0, 0, 1'b1);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && u_checker.error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+design
design/act_pkg.sv
design/pipe_stage.sv
design/hardswish_prep.sv
design/hardswish_mult.sv
design/hardswish_pipeline.sv
verif/hardswish_checker.sv
verif/tb_hardswish.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the HardSwish testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f files.f \
  --top-module tb_hardswish \
  -o sim_hardswish

./obj_dir/sim_hardswish | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation finished without failures"
